/* logic/uart_slave_consts.svh */
`ifndef UART_SLAVE_CONSTS_SVH
`define UART_SLAVE_CONSTS_SVH

// word carried on every UART link and on the serial master lines
`define UART_DATA_WIDTH        32

// control frame layout: code bits, slave id, read/write bit
`define UART_ID_WIDTH          2
`define UART_CODE_WIDTH        3
`define UART_FRAME_LEN         6

// status nibble streamed ahead of a read word
`define UART_STATUS_BITS       4

// reply wait per send, in clock cycles
`define UART_ACK_TIMEOUT       64

// extra sends after the first one
`define UART_RETRANSMIT_TIMES  3

// reply codes, zero-extended to a full word on the links
`define UART_ACK_CODE          8'hCC
`define UART_NAK_CODE          8'hAA

`endif

/* logic/uart_slave_pkg.sv */
`default_nettype none

`include "uart_slave_consts.svh"

package uart_slave_pkg;

    // one data word on any link
    typedef logic [`UART_DATA_WIDTH-1:0] word_t;

    // request toward a UART transmitter
    typedef struct packed {
        logic  start;
        word_t data;
    } tx_req_t;

    // word handed over by a UART receiver
    typedef struct packed {
        logic  done;
        word_t data;
    } rx_in_t;

    // session opened by the control decoder
    typedef struct packed {
        logic active;
        logic is_write;
    } session_t;

    // outcome of a write, valid for one cycle
    typedef struct packed {
        logic valid;
        logic acked;
    } write_status_t;

    typedef enum logic [`UART_CODE_WIDTH-1:0] {
        ABORT = 3'b100,
        START = 3'b111
    } frame_code_e;

    typedef enum logic [1:0] {IDLE, FRAME, SESSION} decoder_state_e;
    typedef enum logic [1:0] {SHIFT, SEND, WAIT_REPLY} write_state_e;
    typedef enum logic [1:0] {WAIT_DATA, SEND_ACK, STREAM} read_state_e;

endpackage

`default_nettype wire

/* logic/control_decoder.sv */
`default_nettype none
`timescale 1ns/100ps

`include "uart_slave_consts.svh"

module control_decoder
    import uart_slave_pkg::*;
#(
    parameter int unsigned SLAVE_ID = 1
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     control,
    input  logic     write_done,
    input  logic     read_done,
    output session_t session
);

    localparam int unsigned FRAME_LEN = `UART_FRAME_LEN;
    localparam int unsigned CODE_W    = `UART_CODE_WIDTH;
    localparam int unsigned ID_W      = `UART_ID_WIDTH;
    localparam int unsigned CNT_W     = $clog2(FRAME_LEN);

    decoder_state_e         state;
    logic [FRAME_LEN-2:0]   frame_q;
    logic [FRAME_LEN-1:0]   frame_next;
    logic [CNT_W-1:0]       bit_cnt;
    logic                   is_write_q;
    frame_code_e            code;
    logic [ID_W-1:0]        frame_id;
    logic                   id_match;

    // frame as it stands once the current control bit is in
    assign frame_next = {frame_q, control};
    assign code       = frame_code_e'(frame_next[FRAME_LEN-1 -: CODE_W]);
    assign frame_id   = frame_next[1 +: ID_W];
    assign id_match   = (frame_id == ID_W'(SLAVE_ID));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= IDLE;
            frame_q    <= '0;
            bit_cnt    <= '0;
            is_write_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // first high bit is the first code bit
                    if (control) begin
                        frame_q <= frame_next[FRAME_LEN-2:0];
                        bit_cnt <= CNT_W'(1);
                        state   <= FRAME;
                    end
                end
                FRAME: begin
                    frame_q <= frame_next[FRAME_LEN-2:0];
                    if (bit_cnt == CNT_W'(FRAME_LEN - 1)) begin
                        bit_cnt <= '0;
                        case (code)
                            START: begin
                                if (id_match) begin
                                    is_write_q <= frame_next[0];
                                    state      <= SESSION;
                                end else begin
                                    state <= IDLE;
                                end
                            end
                            default: state <= IDLE;
                        endcase
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                SESSION: begin
                    // a new frame drops the session and is decoded from its first bit
                    if (control) begin
                        frame_q <= frame_next[FRAME_LEN-2:0];
                        bit_cnt <= CNT_W'(1);
                        state   <= FRAME;
                    end else if (write_done || read_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign session = '{active: (state == SESSION), is_write: is_write_q};

endmodule

`default_nettype wire

/* logic/write_forwarder.sv */
`default_nettype none
`timescale 1ns/100ps

`include "uart_slave_consts.svh"

module write_forwarder
    import uart_slave_pkg::*;
(
    input  logic          clk,
    input  logic          rstN,
    input  session_t      session,
    input  logic          wd,
    input  logic          valid,
    output tx_req_t       send_tx,
    input  logic          send_tx_ready,
    input  rx_in_t        send_rx,
    output logic          write_done,
    output write_status_t write_status
);

    localparam int unsigned W         = `UART_DATA_WIDTH;
    localparam int unsigned BIT_CNT_W = $clog2(W);
    localparam int unsigned TIMEOUT   = `UART_ACK_TIMEOUT;
    localparam int unsigned TIMER_W   = $clog2(TIMEOUT);
    localparam int unsigned MAX_SENDS = 1 + `UART_RETRANSMIT_TIMES;
    localparam int unsigned SENDS_W   = $clog2(MAX_SENDS + 1);
    localparam word_t       ACK_WORD  = word_t'(`UART_ACK_CODE);

    write_state_e         state;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [TIMER_W-1:0]   timer;
    logic [SENDS_W-1:0]   sends;
    word_t                shift_q;
    word_t                word_q;
    logic                 busy;
    logic                 shift_en;
    logic                 tx_start;

    // nothing moves once the result is out, until the session closes
    assign busy     = session.active && session.is_write && !write_done;
    assign shift_en = busy && (state == SHIFT) && valid;
    assign tx_start = busy && (state == SEND) && send_tx_ready;

    // msb first, one bit per valid cycle
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shift_q <= {shift_q[W-2:0], wd};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state        <= SHIFT;
            bit_cnt      <= '0;
            timer        <= '0;
            sends        <= '0;
            word_q       <= '0;
            write_done   <= 1'b0;
            write_status <= '0;
        end else begin
            write_done         <= 1'b0;
            write_status.valid <= 1'b0;
            if (tx_start) begin
                word_q <= shift_q;
            end
            if (!(session.active && session.is_write)) begin
                state   <= SHIFT;
                bit_cnt <= '0;
                timer   <= '0;
                sends   <= '0;
            end else if (busy) begin
                case (state)
                    SHIFT: begin
                        if (valid) begin
                            if (bit_cnt == BIT_CNT_W'(W - 1)) begin
                                state <= SEND;
                            end else begin
                                bit_cnt <= bit_cnt + 1'b1;
                            end
                        end
                    end
                    SEND: begin
                        if (send_tx_ready) begin
                            timer <= '0;
                            sends <= sends + 1'b1;
                            state <= WAIT_REPLY;
                        end
                    end
                    WAIT_REPLY: begin
                        if (send_rx.done) begin
                            write_done         <= 1'b1;
                            write_status.valid <= 1'b1;
                            write_status.acked <= (send_rx.data == ACK_WORD);
                            state              <= SHIFT;
                        end else if (timer == TIMER_W'(TIMEOUT - 1)) begin
                            // out of retries counts as nak
                            if (sends == SENDS_W'(MAX_SENDS)) begin
                                write_done         <= 1'b1;
                                write_status.valid <= 1'b1;
                                write_status.acked <= 1'b0;
                                state              <= SHIFT;
                            end else begin
                                state <= SEND;
                            end
                        end else begin
                            timer <= timer + 1'b1;
                        end
                    end
                    default: state <= SHIFT;
                endcase
            end
        end
    end

    // new word appears together with its start, then held
    assign send_tx = '{start: tx_start, data: tx_start ? shift_q : word_q};

endmodule

`default_nettype wire

/* logic/read_returner.sv */
`default_nettype none
`timescale 1ns/100ps

`include "uart_slave_consts.svh"

module read_returner
    import uart_slave_pkg::*;
(
    input  logic          clk,
    input  logic          rstN,
    input  session_t      session,
    input  write_status_t write_status,
    input  rx_in_t        get_rx,
    output tx_req_t       get_tx,
    input  logic          get_tx_ready,
    output logic          ready,
    output logic          rd,
    output logic          read_done
);

    localparam int unsigned W           = `UART_DATA_WIDTH;
    localparam int unsigned STATUS_BITS = `UART_STATUS_BITS;
    localparam int unsigned STREAM_LEN  = STATUS_BITS + W;
    localparam int unsigned CNT_W       = $clog2(STREAM_LEN);
    localparam logic [7:0]  ACK_CODE    = `UART_ACK_CODE;
    localparam logic [7:0]  NAK_CODE    = `UART_NAK_CODE;
    localparam word_t       ACK_WORD    = word_t'(`UART_ACK_CODE);

    read_state_e            state;
    logic [STATUS_BITS-1:0] status_q;
    logic [STREAM_LEN-1:0]  stream_q;
    logic [CNT_W-1:0]       bit_cnt;
    logic                   rd_active;
    logic                   busy;
    logic                   capture;
    logic                   streaming;
    logic                   tx_start;

    assign rd_active = session.active && !session.is_write;
    assign busy      = rd_active && !read_done;
    assign capture   = busy && (state == WAIT_DATA) && get_rx.done;
    assign streaming = busy && (state == STREAM);
    assign tx_start  = busy && (state == SEND_ACK) && get_tx_ready;

    // upper nibble of the last write's reply code
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            status_q <= '0;
        end else if (write_status.valid) begin
            status_q <= write_status.acked ? ACK_CODE[7 -: STATUS_BITS]
                                           : NAK_CODE[7 -: STATUS_BITS];
        end
    end

    // status then word, shifted out msb first
    always_ff @(posedge clk) begin
        if (capture) begin
            stream_q <= {status_q, get_rx.data};
        end else if (streaming) begin
            stream_q <= {stream_q[STREAM_LEN-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= WAIT_DATA;
            bit_cnt   <= '0;
            read_done <= 1'b0;
        end else begin
            read_done <= 1'b0;
            if (!rd_active) begin
                state   <= WAIT_DATA;
                bit_cnt <= '0;
            end else if (busy) begin
                case (state)
                    WAIT_DATA: begin
                        if (get_rx.done) begin
                            state <= SEND_ACK;
                        end
                    end
                    SEND_ACK: begin
                        if (get_tx_ready) begin
                            bit_cnt <= '0;
                            state   <= STREAM;
                        end
                    end
                    STREAM: begin
                        if (bit_cnt == CNT_W'(STREAM_LEN - 1)) begin
                            read_done <= 1'b1;
                            state     <= WAIT_DATA;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default: state <= WAIT_DATA;
                endcase
            end
        end
    end

    // low through a read session except while bits go out
    assign ready  = !rd_active || streaming;
    assign rd     = streaming && stream_q[STREAM_LEN-1];
    assign get_tx = '{start: tx_start, data: ACK_WORD};

endmodule

`default_nettype wire

/* logic/uart_slave.sv */
`default_nettype none
`timescale 1ns/100ps

module uart_slave
    import uart_slave_pkg::*;
#(
    parameter int unsigned SLAVE_ID = 1
) (
    input  logic    clk,
    input  logic    rstN,

    // serial lines to the master
    input  logic    control,
    input  logic    wd,
    input  logic    valid,
    output logic    ready,
    output logic    rd,

    // upstream neighbor, read path
    input  rx_in_t  get_rx,
    output tx_req_t get_tx,
    input  logic    get_tx_ready,

    // downstream neighbor, write path
    input  rx_in_t  send_rx,
    output tx_req_t send_tx,
    input  logic    send_tx_ready
);

    session_t      session;
    write_status_t write_status;
    logic          write_done;
    logic          read_done;

    control_decoder #(
        .SLAVE_ID (SLAVE_ID)
    ) u_control_decoder (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .write_done (write_done),
        .read_done  (read_done),
        .session    (session)
    );

    write_forwarder u_write_forwarder (
        .clk           (clk),
        .rstN          (rstN),
        .session       (session),
        .wd            (wd),
        .valid         (valid),
        .send_tx       (send_tx),
        .send_tx_ready (send_tx_ready),
        .send_rx       (send_rx),
        .write_done    (write_done),
        .write_status  (write_status)
    );

    // status from the write side feeds the next read
    read_returner u_read_returner (
        .clk          (clk),
        .rstN         (rstN),
        .session      (session),
        .write_status (write_status),
        .get_rx       (get_rx),
        .get_tx       (get_tx),
        .get_tx_ready (get_tx_ready),
        .ready        (ready),
        .rd           (rd),
        .read_done    (read_done)
    );

endmodule

`default_nettype wire

/* verification/uart_slave_properties.sv */
`default_nettype none
`timescale 1ns/100ps

module uart_slave_properties
    import uart_slave_pkg::*;
(
    input logic    clk,
    input logic    rstN,
    input tx_req_t send_tx,
    input logic    send_tx_ready,
    input tx_req_t get_tx,
    input logic    get_tx_ready
);

    // starts are single-cycle pulses
    send_start_pulse: assert property (
        @(posedge clk) disable iff (!rstN) send_tx.start |=> !send_tx.start
    ) else $error("send_tx start held high for more than one cycle");

    get_start_pulse: assert property (
        @(posedge clk) disable iff (!rstN) get_tx.start |=> !get_tx.start
    ) else $error("get_tx start held high for more than one cycle");

    // a transmitter only takes a start while it is ready
    send_start_ready: assert property (
        @(posedge clk) disable iff (!rstN) send_tx.start |-> send_tx_ready
    ) else $error("send_tx start issued while send_tx_ready was low");

    get_start_ready: assert property (
        @(posedge clk) disable iff (!rstN) get_tx.start |-> get_tx_ready
    ) else $error("get_tx start issued while get_tx_ready was low");

    // downstream word only moves together with a start
    send_word_stable: assert property (
        @(posedge clk) disable iff (!rstN) !send_tx.start |-> $stable(send_tx.data)
    ) else $error("send_tx data changed between starts");

endmodule

bind uart_slave uart_slave_properties u_uart_slave_properties (
    .clk           (clk),
    .rstN          (rstN),
    .send_tx       (send_tx),
    .send_tx_ready (send_tx_ready),
    .get_tx        (get_tx),
    .get_tx_ready  (get_tx_ready)
);

`default_nettype wire

/* verification/uart_slave_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "uart_slave_consts.svh"

module uart_slave_tb
    import uart_slave_pkg::*;
();

    localparam int         SLAVE_ID    = 1;
    localparam int         N_ENTRIES   = 14;
    localparam int         CYCLE_LIMIT = N_ENTRIES * 5 * `UART_ACK_TIMEOUT;
    localparam int         STREAM_LEN  = `UART_STATUS_BITS + `UART_DATA_WIDTH;
    localparam int         MAX_SENDS   = 1 + `UART_RETRANSMIT_TIMES;
    localparam logic [7:0] ACK_CODE    = `UART_ACK_CODE;
    localparam logic [7:0] NAK_CODE    = `UART_NAK_CODE;
    localparam word_t      ACK_WORD    = word_t'(ACK_CODE);
    localparam word_t      NAK_WORD    = word_t'(NAK_CODE);
    localparam logic [1:0] REPLY_NONE  = 2'd0;
    localparam logic [1:0] REPLY_ACK   = 2'd1;
    localparam logic [1:0] REPLY_NAK   = 2'd2;

    typedef struct packed {
        logic       is_write;
        logic [2:0] code;
        logic [1:0] id;
        word_t      data;
        logic [1:0] reply;
        logic       abort;
        word_t      exp_word;
        int         exp_sends;
        logic [3:0] exp_status;
    } entry_t;

    logic    clk;
    logic    rstN;
    logic    control;
    logic    wd;
    logic    valid;
    logic    ready;
    logic    rd;
    logic    get_tx_ready;
    logic    send_tx_ready;
    rx_in_t  get_rx;
    rx_in_t  send_rx;
    tx_req_t get_tx;
    tx_req_t send_tx;

    entry_t     entries [N_ENTRIES];
    int         seed = 16277;
    logic [3:0] model_status = 4'h0;
    int         cycles = 0;
    int         checks = 0;
    int         errors = 0;
    int         entry_errors = 0;
    int         send_starts = 0;
    int         get_starts = 0;
    int         ready_low = 0;
    word_t      send_word;
    word_t      get_word;

    always #2 clk = ~clk;

    uart_slave #(
        .SLAVE_ID (SLAVE_ID)
    ) u_uart_slave (
        .clk           (clk),
        .rstN          (rstN),
        .control       (control),
        .wd            (wd),
        .valid         (valid),
        .ready         (ready),
        .rd            (rd),
        .get_rx        (get_rx),
        .get_tx        (get_tx),
        .get_tx_ready  (get_tx_ready),
        .send_rx       (send_rx),
        .send_tx       (send_tx),
        .send_tx_ready (send_tx_ready)
    );

    // neighbor transmitters and the master's ready line, sampled mid-cycle
    always @(negedge clk) begin
        if (send_tx.start) begin
            send_starts = send_starts + 1;
            send_word   = send_tx.data;
        end
        if (get_tx.start) begin
            get_starts = get_starts + 1;
            get_word   = get_tx.data;
        end
        if (!ready) begin
            ready_low = ready_low + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run hung: entries still running after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks = checks + 1;
        if (actual !== expected) begin
            errors       = errors + 1;
            entry_errors = entry_errors + 1;
            $display("Fail %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // expected sends and status follow the reply rules of the node
    function automatic void add_entry(input int idx, input logic is_write,
                                      input logic [2:0] code, input logic [1:0] id,
                                      input logic [1:0] reply, input logic abort);
        logic selected;
        selected = (code == START) && (id == 2'(SLAVE_ID));
        entries[idx].is_write   = is_write;
        entries[idx].code       = code;
        entries[idx].id         = id;
        entries[idx].reply      = reply;
        entries[idx].abort      = abort;
        entries[idx].data       = $random(seed);
        entries[idx].exp_word   = entries[idx].data;
        entries[idx].exp_status = model_status;
        entries[idx].exp_sends  = 0;
        if (is_write && selected && !abort) begin
            entries[idx].exp_sends = (reply == REPLY_NONE) ? MAX_SENDS : 1;
            model_status = (reply == REPLY_ACK) ? ACK_CODE[7:4] : NAK_CODE[7:4];
        end
    endfunction

    function automatic void fill_table();
        add_entry(0,  1'b0, START, 2'd1, REPLY_NONE, 1'b0);
        add_entry(1,  1'b1, START, 2'd1, REPLY_ACK,  1'b0);
        add_entry(2,  1'b0, START, 2'd1, REPLY_NONE, 1'b0);
        add_entry(3,  1'b1, START, 2'd1, REPLY_NAK,  1'b0);
        add_entry(4,  1'b0, START, 2'd1, REPLY_NONE, 1'b0);
        add_entry(5,  1'b1, START, 2'd1, REPLY_ACK,  1'b0);
        add_entry(6,  1'b1, START, 2'd1, REPLY_NONE, 1'b0);
        add_entry(7,  1'b0, START, 2'd1, REPLY_NONE, 1'b0);
        add_entry(8,  1'b1, START, 2'd1, REPLY_ACK,  1'b0);
        add_entry(9,  1'b1, START, 2'd2, REPLY_NONE, 1'b0);
        add_entry(10, 1'b1, ABORT, 2'd1, REPLY_NONE, 1'b0);
        add_entry(11, 1'b0, START, 2'd3, REPLY_NONE, 1'b0);
        add_entry(12, 1'b1, START, 2'd1, REPLY_ACK,  1'b1);
        add_entry(13, 1'b0, START, 2'd1, REPLY_NONE, 1'b0);
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // code, id, then read/write bit, msb first
    task automatic send_frame(input logic [2:0] code, input logic [1:0] id, input logic rw);
        logic [5:0] bits;
        bits = {code, id, rw};
        for (int i = 5; i >= 0; i--) begin
            @(posedge clk);
            control <= bits[i];
        end
        @(posedge clk);
        control <= 1'b0;
    endtask

    task automatic send_bits(input word_t word, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            valid <= 1'b1;
            wd    <= word[`UART_DATA_WIDTH-1-i];
        end
        @(posedge clk);
        valid <= 1'b0;
        wd    <= 1'b0;
    endtask

    task automatic run_write(input entry_t e);
        int waited;
        int send_base;
        int get_base;
        int low_base;
        waited    = 0;
        send_base = send_starts;
        get_base  = get_starts;
        low_base  = ready_low;
        send_frame(e.code, e.id, 1'b1);
        if (e.abort) begin
            // new frame cuts the word in half
            send_bits(e.data, `UART_DATA_WIDTH / 2);
            send_frame(ABORT, e.id, 1'b1);
        end else begin
            send_bits(e.data, `UART_DATA_WIDTH);
        end
        if (e.exp_sends == 0) begin
            wait_cycles(8);
        end else if (e.reply == REPLY_NONE) begin
            // every wait runs into its timeout
            wait_cycles(MAX_SENDS * (`UART_ACK_TIMEOUT + 2) + 8);
        end else begin
            while (send_starts == send_base && waited < 16) begin
                @(posedge clk);
                waited++;
            end
            @(posedge clk);
            send_rx <= '{done: 1'b1, data: (e.reply == REPLY_ACK) ? ACK_WORD : NAK_WORD};
            @(posedge clk);
            send_rx.done <= 1'b0;
            wait_cycles(4);
        end
        check_value("downstream starts", send_starts - send_base, e.exp_sends);
        if (e.exp_sends > 0) begin
            check_value("forwarded word", send_word, e.exp_word);
        end
        check_value("upstream starts", get_starts - get_base, 0);
        check_value("cycles with ready low", ready_low - low_base, 0);
    endtask

    task automatic run_read(input entry_t e);
        logic                  selected;
        logic [STREAM_LEN-1:0] got;
        int                    waited;
        int                    high_cycles;
        int                    get_base;
        int                    low_base;
        selected    = (e.code == START) && (e.id == 2'(SLAVE_ID));
        got         = '0;
        waited      = 0;
        high_cycles = 0;
        get_base    = get_starts;
        low_base    = ready_low;
        send_frame(e.code, e.id, 1'b0);
        @(posedge clk);
        get_rx <= '{done: 1'b1, data: e.data};
        @(posedge clk);
        get_rx.done <= 1'b0;
        if (selected) begin
            @(negedge clk);
            check_value("ready before streaming", 32'(ready), 32'd0);
            while (!ready && waited < 16) begin
                @(negedge clk);
                waited++;
            end
            for (int i = 0; i < STREAM_LEN; i++) begin
                if (ready) begin
                    high_cycles++;
                end
                got = {got[STREAM_LEN-2:0], rd};
                @(negedge clk);
            end
            check_value("ready after last bit", 32'(ready), 32'd0);
            check_value("ready high cycles", high_cycles, STREAM_LEN);
            check_value("streamed status", 32'(got[STREAM_LEN-1 -: 4]), 32'(e.exp_status));
            check_value("streamed word", got[`UART_DATA_WIDTH-1:0], e.data);
            @(negedge clk);
            check_value("ready after read", 32'(ready), 32'd1);
            @(posedge clk);
            check_value("upstream starts", get_starts - get_base, 1);
            check_value("upstream reply", get_word, ACK_WORD);
        end else begin
            wait_cycles(8);
            check_value("upstream starts", get_starts - get_base, 0);
            check_value("cycles with ready low", ready_low - low_base, 0);
        end
    endtask

    initial begin
        string kind;
        clk           = 1'b0;
        rstN          <= 1'b0;
        control       <= 1'b0;
        wd            <= 1'b0;
        valid         <= 1'b0;
        get_rx        <= '0;
        send_rx       <= '0;
        get_tx_ready  <= 1'b1;
        send_tx_ready <= 1'b1;
        fill_table();
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        for (int n = 0; n < N_ENTRIES; n++) begin
            @(posedge clk);
            entry_errors = 0;
            if (entries[n].is_write) begin
                kind = "write";
                run_write(entries[n]);
            end else begin
                kind = "read";
                run_read(entries[n]);
            end
            $display("entry %0d %s finished, %0d mismatches", n, kind, entry_errors);
        end
        $display("entries %0d, checks %0d, mismatches %0d", N_ENTRIES, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
logic/uart_slave_pkg.sv
logic/control_decoder.sv
logic/write_forwarder.sv
logic/read_returner.sv
logic/uart_slave.sv
verification/uart_slave_properties.sv
verification/uart_slave_tb.sv

/* Makefile */
TOP := uart_slave_tb

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean
